// File: test/acia_vectors.txt
# columns: cmd then hex fields, W rs value, R rs expect, S byte stop, T byte, F byte, Q irq
# data writes are mirrored into the io fifo and popped by the F lines
W 0 01
R 0 02
Q 0
W 1 A5
W 1 3C
T A5
T 3C
R 0 02
W 0 81
S 5A 1
Q 1
R 0 83
R 1 5A
Q 0
W 0 01
S 55 1
S AA 1
R 0 23
R 1 55
R 0 02
S 0F 1
S 3C 0
R 0 33
W 0 03
R 0 02
W 0 21
Q 1
R 0 82
W 0 03
W 1 11
W 1 22
W 1 33
W 1 44
F A5
F 3C
F 11
F 22
F 33
F 44

// File: acia.f
hdl/acia_pkg.sv
hdl/acia_bus_if.sv
hdl/acia_reg_decode.sv
hdl/acia_baud_gen.sv
hdl/acia_receiver.sv
hdl/acia_transmitter.sv
hdl/acia_status_read.sv
hdl/io_fifo.sv
hdl/acia_top.sv
test/acia_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f acia.f --top-module acia_tb -o acia_sim

output=$(./obj_dir/acia_sim || true)
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
	exit 0
else
	exit 1
fi

// File: test/acia_tb.sv
`timescale 1ns/1ns

module acia_tb;

	logic       clk;
	logic       reset;
	logic       e;
	logic       sel;
	logic       rs;
	logic       rw;
	logic [7:0] din;
	logic [7:0] dout;
	logic       irq;
	logic       tx;
	logic       rx;
	logic       serial_data_out_valid;
	logic       serial_data_out_ready;
	logic [7:0] serial_data_out;

	int         checks;
	int         errors;
	int         cycles;
	int         limit;
	// tx frames written but not yet captured
	int         pending;
	logic [7:0] cr_mirror;

	acia_top #(.FIFO_DEPTH(16)) dut (
		.clk(clk), .reset(reset), .e(e), .sel(sel), .rs(rs), .rw(rw), .din(din),
		.dout(dout), .irq(irq), .tx(tx), .rx(rx),
		.serial_data_out_valid(serial_data_out_valid),
		.serial_data_out_ready(serial_data_out_ready),
		.serial_data_out(serial_data_out)
	);

	always #50 clk = ~clk;

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERR %0t %s expected %02h actual %02h", $time, name, exp, got);
		end
	endtask

	// one cpu bus cycle, E high for 4 clk
	task automatic cpu_access(input logic rw_i, input logic rs_i, input logic [7:0] d,
		output logic [7:0] q);
		@(negedge clk);
		sel = 1'b1;
		rs = rs_i;
		rw = rw_i;
		din = d;
		e = 1'b1;
		repeat (4) @(negedge clk);
		// dout settled while E still high
		q = dout;
		e = 1'b0;
		sel = 1'b0;
		rw = 1'b1;
		// strobe plus register update
		repeat (3) @(negedge clk);
	endtask

	// 8N1 frame into rx, 1024 clk per bit
	task automatic send_frame(input logic [7:0] data, input logic stop);
		logic [9:0] frame;
		int i;
		frame = {stop, data, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(negedge clk);
			rx = frame[i];
			repeat (1023) @(negedge clk);
		end
		@(negedge clk);
		rx = 1'b1;
	endtask

	// start edge, then mid-bit samples
	task automatic capture_frame(input logic [7:0] exp);
		logic [7:0] data;
		int i;
		@(negedge clk);
		while (tx !== 1'b0) @(negedge clk);
		repeat (512) @(negedge clk);
		check_value("tx", 8'h00, {7'd0, tx});
		for (i = 0; i < 8; i++) begin
			repeat (1024) @(negedge clk);
			data[i] = tx;
		end
		check_value("tx", exp, data);
		repeat (1024) @(negedge clk);
		check_value("tx", 8'h01, {7'd0, tx});
		pending--;
		// run to the end of the stop bit
		repeat (512) @(negedge clk);
	endtask

	// random ready, data must hold while stalled
	task automatic pop_fifo(input logic [7:0] exp);
		logic        v;
		logic [7:0]  d;
		logic        held;
		logic [7:0]  held_d;
		logic [31:0] r;
		logic        done;
		held = 1'b0;
		held_d = 8'h00;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			v = serial_data_out_valid;
			d = serial_data_out;
			if (held) begin
				check_value("serial_data_out_valid", 8'h01, {7'd0, v});
				check_value("serial_data_out", held_d, d);
			end
			r = $urandom;
			serial_data_out_ready = r[0];
			held = v && !r[0];
			held_d = d;
			// transfer at the coming rising edge
			if (v && r[0]) begin
				check_value("serial_data_out", exp, d);
				done = 1'b1;
			end
		end
		@(negedge clk);
		serial_data_out_ready = 1'b0;
	endtask

	// line rests high with nothing queued
	always @(negedge clk) begin
		if (!reset && pending == 0) begin
			check_value("tx", 8'h01, {7'd0, tx});
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit != 0 && cycles > limit) begin
			$display("timeout, run went past %0d clock cycles", limit);
			$display("checks %0d errors %0d", checks, errors);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		int          fd;
		int          c;
		int          n;
		int          n_lines;
		logic [7:0]  cmd;
		logic [31:0] a;
		logic [31:0] b;
		logic [7:0]  q;
		clk = 1'b0;
		reset = 1'b1;
		e = 1'b0;
		sel = 1'b0;
		rs = 1'b0;
		rw = 1'b1;
		din = 8'h00;
		rx = 1'b1;
		serial_data_out_ready = 1'b0;
		checks = 0;
		errors = 0;
		cycles = 0;
		limit = 0;
		pending = 0;
		cr_mirror = 8'h03;
		n_lines = 0;
		void'($urandom(56));

		fd = $fopen("test/acia_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open test/acia_vectors.txt");
			$display("TEST RESULT: FAIL");
			$finish;
		end
		// line count sets the timeout
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == 10) n_lines++;
			c = $fgetc(fd);
		end
		$fclose(fd);
		limit = (n_lines + 1) * 16000;
		fd = $fopen("test/acia_vectors.txt", "r");

		repeat (5) @(negedge clk);
		reset = 1'b0;

		n = $fscanf(fd, "%s", cmd);
		while (n == 1) begin
			case (cmd)
				"#": begin
					c = $fgetc(fd);
					while (c != 10 && c != -1) c = $fgetc(fd);
				end
				"W": begin
					n = $fscanf(fd, "%h %h", a, b);
					cpu_access(1'b0, a[0], b[7:0], q);
					if (!a[0]) begin
						cr_mirror = b[7:0];
						// master reset drops any frame in flight
						if (b[1:0] == 2'b11) pending = 0;
					end else if (cr_mirror[1:0] != 2'b11) begin
						pending++;
					end
				end
				"R": begin
					n = $fscanf(fd, "%h %h", a, b);
					cpu_access(1'b1, a[0], 8'h00, q);
					check_value("dout", b[7:0], q);
				end
				"S": begin
					n = $fscanf(fd, "%h %h", a, b);
					send_frame(a[7:0], b[0]);
				end
				"T": begin
					n = $fscanf(fd, "%h", a);
					capture_frame(a[7:0]);
				end
				"F": begin
					n = $fscanf(fd, "%h", a);
					pop_fifo(a[7:0]);
				end
				"Q": begin
					n = $fscanf(fd, "%h", a);
					@(negedge clk);
					check_value("irq", {7'd0, a[0]}, {7'd0, irq});
				end
				default: begin
					errors++;
					$display("unknown vector command %s", cmd);
				end
			endcase
			n = $fscanf(fd, "%s", cmd);
		end
		$fclose(fd);

		// every byte popped, fifo empty
		@(negedge clk);
		check_value("serial_data_out_valid", 8'h00, {7'd0, serial_data_out_valid});

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: hdl/acia_top.sv
`timescale 1ns/1ns

module acia_top #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic       clk,
	input  logic       reset,
	// cpu register port
	input  logic       e,
	input  logic       sel,
	input  logic       rs,
	input  logic       rw,
	input  logic [7:0] din,
	output logic [7:0] dout,
	output logic       irq,
	// serial line
	output logic       tx,
	input  logic       rx,
	// copy of cpu data writes for the io controller
	output logic       serial_data_out_valid,
	input  logic       serial_data_out_ready,
	output logic [7:0] serial_data_out
);
	import acia_pkg::*;

	acia_bus_if bus ();

	logic       tick;
	logic [7:0] rx_data;
	logic       rdrf;
	logic       fe;
	logic       ovrn;
	logic       tdre;

	acia_reg_decode u_decode (
		.clk(clk), .reset(reset), .e(e), .sel(sel), .rs(rs), .rw(rw),
		.din(din), .bus(bus.decode)
	);

	acia_baud_gen u_baud (
		.clk(clk), .reset(reset),
		.rate(rate_t'(bus.cr[cr_rate_lsb +: 2])), .tick(tick)
	);

	acia_receiver u_rx (
		.clk(clk), .reset(reset), .rx(rx), .tick(tick), .bus(bus.rx),
		.rx_data(rx_data), .rdrf(rdrf), .fe(fe), .ovrn(ovrn)
	);

	acia_transmitter u_tx (
		.clk(clk), .reset(reset), .tick(tick), .bus(bus.tx),
		.tx(tx), .tdre(tdre)
	);

	acia_status_read u_status (
		.sel(sel), .rs(rs), .rw(rw), .bus(bus.status), .rx_data(rx_data),
		.rdrf(rdrf), .tdre(tdre), .fe(fe), .ovrn(ovrn), .dout(dout), .irq(irq)
	);

	// every data register write is mirrored here
	io_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk(clk), .reset(reset), .push(bus.wr_data), .push_data(bus.wdata),
		.out_valid(serial_data_out_valid), .out_data(serial_data_out),
		.out_ready(serial_data_out_ready)
	);

endmodule

// File: hdl/io_fifo.sv
`timescale 1ns/1ns

module io_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       push,
	input  logic [7:0] push_data,
	output logic       out_valid,
	output logic [7:0] out_data,
	input  logic       out_ready
);

	localparam int aw = $clog2(FIFO_DEPTH);

	logic [7:0] mem [FIFO_DEPTH];
	// extra msb tells full from empty
	logic [aw:0] wr_ptr;
	logic [aw:0] rd_ptr;
	logic [aw:0] count;
	logic        full;
	logic        pop;

	assign count = wr_ptr - rd_ptr;
	assign full = (count == (aw+1)'(FIFO_DEPTH));
	assign out_valid = (wr_ptr != rd_ptr);
	assign pop = out_valid && out_ready;
	assign out_data = mem[rd_ptr[aw-1:0]];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			// a byte into a full buffer is lost
			if (push && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push && !full) begin
			mem[wr_ptr[aw-1:0]] <= push_data;
		end
	end

	a_count_range: assert property (@(posedge clk) disable iff (reset)
		count <= (aw+1)'(FIFO_DEPTH));

endmodule

// File: hdl/acia_status_read.sv
`timescale 1ns/1ns

module acia_status_read (
	input  logic         sel,
	input  logic         rs,
	input  logic         rw,
	acia_bus_if.status   bus,
	input  logic [7:0]   rx_data,
	input  logic         rdrf,
	input  logic         tdre,
	input  logic         fe,
	input  logic         ovrn,
	output logic [7:0]   dout,
	output logic         irq
);
	import acia_pkg::*;

	logic [7:0] status;

	// rx full or tx empty, each with its own enable
	assign irq = (bus.cr[cr_rx_irq_bit] && rdrf) ||
		((bus.cr[cr_tx_ctrl_lsb +: 2] == tx_irq_code) && tdre);

	always_comb begin
		// parity, cts and dcd read as zero
		status = 8'h00;
		status[st_rdrf] = rdrf;
		status[st_tdre] = tdre;
		status[st_fe] = fe;
		status[st_ovrn] = ovrn;
		status[st_irq] = irq;

		dout = 8'h00;
		if (sel && rw) begin
			dout = rs ? rx_data : status;
		end
	end

endmodule

// File: hdl/acia_transmitter.sv
`timescale 1ns/1ns

module acia_transmitter (
	input  logic   clk,
	input  logic   reset,
	input  logic   tick,
	acia_bus_if.tx bus,
	output logic   tx,
	output logic   tdre
);
	import acia_pkg::*;

	// ten bits of sixteen ticks, plus one to reach the slot edge
	localparam logic [7:0] tx_load = {4'(frame_bits), 4'd1};

	logic [frame_bits:0] shift;
	logic [7:0]          cnt;
	// holding buffer
	logic [7:0]          hold;
	logic                hold_valid;
	logic                step;
	logic                idle;
	logic                mreset;

	// shift only while a rate is selected
	assign step = tick && (bus.cr[cr_rate_lsb +: 2] inside {rate_div16, rate_div64});

	// master reset acts at the control write already
	assign mreset = bus.master_reset ||
		(bus.wr_ctrl && bus.wdata[cr_rate_lsb +: 2] == rate_master_reset);

	// free now, or the last frame ends this cycle with nothing held
	assign idle = (cnt == 8'd0) || (step && cnt == 8'd1 && !hold_valid);

	always_ff @(posedge clk) begin
		if (reset || mreset) begin
			shift <= '1;
			cnt <= 8'd0;
			tdre <= 1'b1;
			hold_valid <= 1'b0;
		end else begin
			if (step) begin
				// one bit per 16 ticks, ones fill from the top
				if (cnt[3:0] == 4'd0) begin
					shift <= {1'b1, shift[frame_bits:1]};
				end
				if (cnt != 8'd0) begin
					cnt <= cnt - 8'd1;
				end
				// last tick of the frame
				if (cnt == 8'd1) begin
					if (hold_valid) begin
						// back to back from the buffer
						shift <= {1'b1, hold, 1'b0, 1'b1};
						cnt <= tx_load;
						hold_valid <= 1'b0;
					end else begin
						tdre <= 1'b1;
					end
				end
			end

			if (bus.wr_data) begin
				if (idle) begin
					// stop, data lsb first, start, idle one
					shift <= {1'b1, bus.wdata, 1'b0, 1'b1};
					cnt <= tx_load;
					tdre <= 1'b0;
				end else begin
					hold_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus.wr_data && !idle) begin
			hold <= bus.wdata;
		end
	end

	assign tx = tdre ? 1'b1 : shift[0];

	// an idle shifter also rests on a high bit
	a_idle_high: assert property (@(posedge clk) disable iff (reset)
		tdre |-> (tx && shift[0]));

endmodule

// File: hdl/acia_receiver.sv
`timescale 1ns/1ns

module acia_receiver (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	input  logic       tick,
	acia_bus_if.rx     bus,
	output logic [7:0] rx_data,
	output logic       rdrf,
	output logic       fe,
	output logic       ovrn
);
	import acia_pkg::*;

	// nine bits to go, first sample half a bit from now
	localparam logic [7:0] rx_load = {4'd9, 4'd7};

	logic [filter_len-1:0] filter;
	// filtered line level
	logic                  line;
	// upper nibble bits, lower nibble sub-ticks
	logic [7:0]            cnt;
	logic [7:0]            shift;

	always_ff @(posedge clk) begin
		if (reset || bus.master_reset) begin
			filter <= '1;
			line <= 1'b1;
			cnt <= 8'd0;
			rdrf <= 1'b0;
			fe <= 1'b0;
			ovrn <= 1'b0;
		end else begin
			filter <= {filter[filter_len-2:0], rx};
			// line only moves after four equal samples
			if (filter == '0) begin
				line <= 1'b0;
			end else if (filter == '1) begin
				line <= 1'b1;
			end

			// data read clears rx status
			if (bus.rd_data) begin
				rdrf <= 1'b0;
				ovrn <= 1'b0;
			end

			if (tick) begin
				if (cnt == 8'd0) begin
					// idle, wait for a start bit
					if (!line) begin
						cnt <= rx_load;
					end
				end else begin
					cnt <= cnt - 8'd1;
					// stop bit
					if (cnt == 8'd1) begin
						if (line) begin
							rdrf <= 1'b1;
							fe <= 1'b0;
						end else begin
							fe <= 1'b1;
						end
						// previous byte never read
						if (rdrf) begin
							ovrn <= 1'b1;
						end
					end
				end
			end
		end
	end

	// shifter and data register
	always_ff @(posedge clk) begin
		if (tick && cnt != 8'd0) begin
			// mid-bit sample into msb, lsb first on the line
			if (cnt[3:0] == 4'd0) begin
				shift <= {line, shift[7:1]};
			end
			// an unread byte is kept
			if (cnt == 8'd1 && line && !rdrf) begin
				rx_data <= shift;
			end
		end
	end

	a_cnt_range: assert property (@(posedge clk) disable iff (reset)
		cnt <= rx_load);

endmodule

// File: hdl/acia_baud_gen.sv
`timescale 1ns/1ns

module acia_baud_gen (
	input  logic           clk,
	input  logic           reset,
	input  acia_pkg::rate_t rate,
	output logic           tick
);
	import acia_pkg::*;

	// free running prescaler
	logic [prescale_w-1:0] cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// 16x tick, once per 64 or 256 clocks
	always_comb begin
		case (rate)
			rate_div16: tick = (cnt[5:0] == 6'd0);
			rate_div64: tick = (cnt[7:0] == 8'd0);
			default:    tick = 1'b0;
		endcase
	end

endmodule

// File: hdl/acia_reg_decode.sv
`timescale 1ns/1ns

module acia_reg_decode (
	input  logic       clk,
	input  logic       reset,
	input  logic       e,
	input  logic       sel,
	input  logic       rs,
	input  logic       rw,
	input  logic [7:0] din,
	acia_bus_if.decode bus
);
	import acia_pkg::*;

	logic       e_d;
	logic       e_fall;
	// bus cycle captured while E is high
	logic       cap_sel;
	logic       cap_rs;
	logic       cap_rw;
	logic [7:0] cap_din;

	// E seen low this cycle after being high
	assign e_fall = e_d & ~e;

	always_ff @(posedge clk) begin
		if (reset) begin
			e_d <= 1'b0;
			cap_sel <= 1'b0;
			bus.wr_ctrl <= 1'b0;
			bus.wr_data <= 1'b0;
			bus.rd_data <= 1'b0;
			bus.cr <= 8'h03;
		end else begin
			e_d <= e;
			// hold the last sampled access, E high phase only
			if (e) begin
				cap_sel <= sel;
			end
			bus.wr_ctrl <= e_fall & cap_sel & ~cap_rw & ~cap_rs;
			bus.wr_data <= e_fall & cap_sel & ~cap_rw & cap_rs;
			bus.rd_data <= e_fall & cap_sel & cap_rw & cap_rs;
			// control byte lands the edge after the strobe
			if (bus.wr_ctrl) begin
				bus.cr <= bus.wdata;
			end
		end
	end

	// payload side of the captured access
	always_ff @(posedge clk) begin
		if (e) begin
			cap_rs <= rs;
			cap_rw <= rw;
			cap_din <= din;
		end
		if (e_fall) begin
			bus.wdata <= cap_din;
		end
	end

	assign bus.master_reset = (bus.cr[cr_rate_lsb +: 2] == rate_master_reset);

	// the three register accesses are exclusive
	a_one_strobe: assert property (@(posedge clk) disable iff (reset)
		$onehot0({bus.wr_ctrl, bus.wr_data, bus.rd_data}));

endmodule

// File: hdl/acia_bus_if.sv
`timescale 1ns/1ns

interface acia_bus_if;

	// one clk strobes, cycle after E falls
	logic       wr_ctrl;
	logic       wr_data;
	logic       rd_data;
	// byte captured during the E high phase
	logic [7:0] wdata;
	// registered control byte
	logic [7:0] cr;
	// rate field holds master reset
	logic       master_reset;

	modport decode (output wr_ctrl, wr_data, rd_data, wdata, cr, master_reset);
	modport rx     (input rd_data, cr, master_reset);
	modport tx     (input wr_data, wr_ctrl, wdata, cr, master_reset);
	modport status (input cr);

endinterface

// File: hdl/acia_pkg.sv
package acia_pkg;

	// rate field of the control byte, 00 gives no ticks
	typedef enum logic [1:0] {
		rate_none         = 2'b00,
		rate_div16        = 2'b01,
		rate_div64        = 2'b10,
		rate_master_reset = 2'b11
	} rate_t;

	// control byte field positions
	localparam int cr_rate_lsb    = 0;
	localparam int cr_tx_ctrl_lsb = 5;
	localparam int cr_rx_irq_bit  = 7;

	// tx control value that enables the tx-empty interrupt
	localparam logic [1:0] tx_irq_code = 2'b01;

	// status byte bit positions
	localparam int st_rdrf = 0;
	localparam int st_tdre = 1;
	localparam int st_fe   = 4;
	localparam int st_ovrn = 5;
	localparam int st_irq  = 7;

	// counter and frame sizes
	localparam int prescale_w = 12;
	localparam int frame_bits = 10;
	localparam int filter_len = 4;

endpackage
